/* compile.f */
verilog/mem_msg_pkg.sv
verilog/mem_req_stage.sv
verilog/mem_delay_stage.sv
verilog/mem_exec_stage.sv
verilog/mem_resp_queue.sv
verilog/mem_server.sv
tb/mem_server_tb.sv

/* tb/mem_server_tb.sv */
/*
 * Memory server testbench
 * Random requests against a reference word memory, with back-pressure,
 * a mid-run reset, a single-request latency check and a watchdog
 */

`timescale 1ns/1ps

module mem_server_tb;

  localparam int clk_period     = 4;
  localparam int reset_cycles   = 10;
  localparam int num_reqs       = 400;
  localparam int drain_cycles   = 200;
  localparam int timeout_cycles =
    num_reqs * (mem_msg_pkg::mem_delay + 3 + 20) + 4 * reset_cycles;

  logic                       clk;
  logic                       rst;
  logic                       req_val;
  logic                       req_rdy;
  mem_msg_pkg::mem_req_msg_t  req_msg;
  logic                       resp_val;
  logic                       resp_rdy;
  mem_msg_pkg::mem_resp_msg_t resp_msg;

  // Reference state
  logic [mem_msg_pkg::data_bits-1:0] model_mem [int];
  mem_msg_pkg::mem_resp_msg_t        exp_q [$];
  int                                error_count;
  int                                check_count;
  int                                resp_count;
  bit                                latency_mode;

  mem_server DUT (
    .clk      (clk),
    .rst      (rst),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Bit mask of the low len bytes, full word for len 0
  function automatic logic [31:0] len_to_mask(input logic [1:0] len);
    if (len == 2'd0) begin
      return 32'hffff_ffff;
    end
    return (32'h1 << (8 * len)) - 32'h1;
  endfunction

  // Applies one accepted request to the model and queues its response
  task automatic apply_model(input mem_msg_pkg::mem_req_msg_t m);
    mem_msg_pkg::mem_resp_msg_t r;
    logic [31:0]                old;
    logic [31:0]                mask;
    int                         idx;
    idx  = int'(m.addr[7:2]);
    mask = len_to_mask(m.len);
    old  = model_mem.exists(idx) ? model_mem[idx] : 32'h0;
    r.op     = m.op;
    r.opaque = m.opaque;
    r.addr   = m.addr;
    r.len    = m.len;
    if (m.op == mem_msg_pkg::mem_op_write) begin
      model_mem[idx] = (old & ~mask) | (m.data & mask);
      r.data = '0;
    end else begin
      r.data = old & mask;
    end
    exp_q.push_back(r);
  endtask

  // 16-word window in addr[7:2], random high and low bits
  function automatic mem_msg_pkg::mem_req_msg_t random_request();
    mem_msg_pkg::mem_req_msg_t m;
    m.op     = ($urandom % 2) ? mem_msg_pkg::mem_op_write : mem_msg_pkg::mem_op_read;
    m.opaque = 8'($urandom);
    m.addr   = {24'($urandom), 2'b00, 4'($urandom), 2'($urandom)};
    m.len    = 2'($urandom);
    m.data   = $urandom;
    return m;
  endfunction

  // Called at a falling edge; returns at the falling edge after acceptance
  task automatic issue_request(input mem_msg_pkg::mem_req_msg_t m);
    bit accepted;
    accepted = 1'b0;
    req_val  = 1'b1;
    req_msg  = m;
    while (!accepted) begin
      @(posedge clk);
      accepted = req_rdy;
    end
    apply_model(m);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    model_mem.delete();
    check("reset resp_val", 32'd0, 32'(resp_val));
    check("reset req_rdy", 32'd1, 32'(req_rdy));
  endtask

  task automatic run_random(input int count);
    for (int i = 0; i < count; i++) begin
      repeat ($urandom % 3) @(negedge clk);
      issue_request(random_request());
    end
  endtask

  // Waits for outstanding responses, bounded in cycles
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d expected responses never arrived", exp_q.size());
      exp_q.delete();
    end
    repeat (4) @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Response side
  // --------------------------------------------------------------------------

  // 70 percent ready, always ready during the latency phase
  always @(negedge clk) begin
    resp_rdy = latency_mode ? 1'b1 : (($urandom % 100) < 70);
  end

  always @(posedge clk) begin : monitor
    mem_msg_pkg::mem_resp_msg_t exp;
    if (!rst && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("A response arrived with no request outstanding");
      end else begin
        exp = exp_q.pop_front();
        check($sformatf("resp %0d op", resp_count), 32'(exp.op), 32'(resp_msg.op));
        check($sformatf("resp %0d opaque", resp_count), 32'(exp.opaque), 32'(resp_msg.opaque));
        check($sformatf("resp %0d addr", resp_count), exp.addr, resp_msg.addr);
        check($sformatf("resp %0d len", resp_count), 32'(exp.len), 32'(resp_msg.len));
        check($sformatf("resp %0d data", resp_count), exp.data, resp_msg.data);
      end
      resp_count++;
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin : main
    int lat;
    void'($urandom(38));
    rst          = 1'b1;
    req_val      = 1'b0;
    req_msg      = '0;
    resp_rdy     = 1'b1;
    latency_mode = 1'b1;
    error_count  = 0;
    check_count  = 0;
    resp_count   = 0;
    apply_reset();

    // Single request into an empty pipeline, edges counted after the accepting one
    issue_request(random_request());
    lat = 0;
    while (!resp_val && lat < 50) begin
      @(negedge clk);
      lat++;
    end
    check("latency", 32'(mem_msg_pkg::mem_delay + 3), 32'(lat));
    drain();
    latency_mode = 1'b0;

    run_random(num_reqs / 2);
    drain();

    // Second reset clears storage and the model alike
    apply_reset();
    run_random(num_reqs / 2);
    drain();

    $display("Checks run: %0d, responses: %0d, errors: %0d",
             check_count, resp_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the request count
  initial begin : watchdog
    #(timeout_cycles * clk_period);
    $display("Watchdog timeout with %0d responses still outstanding", exp_q.size());
    $display("Finished with errors");
    $finish;
  end

endmodule

/* verilog/mem_server.sv */
/*
 * Word memory server
 * Request register, delay line, execute and response queue in a chain
 */

`timescale 1ns/1ps

module mem_server (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       req_val,
  output logic                       req_rdy,
  input  mem_msg_pkg::mem_req_msg_t  req_msg,

  output logic                       resp_val,
  input  logic                       resp_rdy,
  output mem_msg_pkg::mem_resp_msg_t resp_msg
);

  // --------------------------------------------------------------------------
  // Stage links
  // --------------------------------------------------------------------------

  // Request register to delay line
  logic                       req2dly_val;
  logic                       req2dly_rdy;
  mem_msg_pkg::mem_req_msg_t  req2dly_msg;

  // Delay line to execute
  logic                       dly2exe_val;
  logic                       dly2exe_rdy;
  mem_msg_pkg::mem_req_msg_t  dly2exe_msg;

  // Execute to response queue
  logic                       exe2rsp_val;
  logic                       exe2rsp_rdy;
  mem_msg_pkg::mem_resp_msg_t exe2rsp_msg;

  mem_req_stage u_req (
    .clk     (clk),
    .rst     (rst),
    .in_val  (req_val),
    .in_rdy  (req_rdy),
    .in_msg  (req_msg),
    .out_val (req2dly_val),
    .out_rdy (req2dly_rdy),
    .out_msg (req2dly_msg)
  );

  mem_delay_stage u_delay (
    .clk     (clk),
    .rst     (rst),
    .in_val  (req2dly_val),
    .in_rdy  (req2dly_rdy),
    .in_msg  (req2dly_msg),
    .out_val (dly2exe_val),
    .out_rdy (dly2exe_rdy),
    .out_msg (dly2exe_msg)
  );

  mem_exec_stage u_exec (
    .clk     (clk),
    .rst     (rst),
    .in_val  (dly2exe_val),
    .in_rdy  (dly2exe_rdy),
    .in_msg  (dly2exe_msg),
    .out_val (exe2rsp_val),
    .out_rdy (exe2rsp_rdy),
    .out_msg (exe2rsp_msg)
  );

  // Absorbs responses while resp_rdy is low
  mem_resp_queue u_resp (
    .clk     (clk),
    .rst     (rst),
    .in_val  (exe2rsp_val),
    .in_rdy  (exe2rsp_rdy),
    .in_msg  (exe2rsp_msg),
    .out_val (resp_val),
    .out_rdy (resp_rdy),
    .out_msg (resp_msg)
  );

endmodule

/* verilog/mem_resp_queue.sv */
/*
 * Response queue
 * Circular FIFO between execute and the response port
 */

`timescale 1ns/1ps

module mem_resp_queue (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       in_val,
  output logic                       in_rdy,
  input  mem_msg_pkg::mem_resp_msg_t in_msg,

  output logic                       out_val,
  input  logic                       out_rdy,
  output mem_msg_pkg::mem_resp_msg_t out_msg
);

  mem_msg_pkg::mem_resp_msg_t           entries [mem_msg_pkg::resp_depth];
  logic [mem_msg_pkg::resp_ptr_bits-1:0] wr_ptr;
  logic [mem_msg_pkg::resp_ptr_bits-1:0] rd_ptr;
  logic [mem_msg_pkg::resp_ptr_bits:0]   count;
  logic                                  push;
  logic                                  pop;

  // Next slot, wrapping at the last entry
  function automatic logic [mem_msg_pkg::resp_ptr_bits-1:0] ptr_next(
    input logic [mem_msg_pkg::resp_ptr_bits-1:0] ptr
  );
    if (ptr == mem_msg_pkg::resp_ptr_bits'(mem_msg_pkg::resp_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // --------------------------------------------------------------------------
  // Status from count only
  // --------------------------------------------------------------------------

  assign in_rdy  = (count != (mem_msg_pkg::resp_ptr_bits+1)'(mem_msg_pkg::resp_depth));
  assign out_val = (count != '0);
  assign out_msg = entries[rd_ptr];

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  // --------------------------------------------------------------------------
  // Pointers and count
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Simultaneous push and pop leaves count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= in_msg;
    end
  end

endmodule

/* verilog/mem_exec_stage.sv */
/*
 * Execute stage
 * Word storage with per-word written flags; performs masked writes and
 * reads, then builds a registered response
 */

`timescale 1ns/1ps

module mem_exec_stage (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       in_val,
  output logic                       in_rdy,
  input  mem_msg_pkg::mem_req_msg_t  in_msg,

  output logic                       out_val,
  input  logic                       out_rdy,
  output mem_msg_pkg::mem_resp_msg_t out_msg
);

  logic [mem_msg_pkg::data_bits-1:0]      mem [mem_msg_pkg::mem_words];
  logic [mem_msg_pkg::mem_words-1:0]      written;

  logic [mem_msg_pkg::mem_index_bits-1:0] idx;
  logic [mem_msg_pkg::data_bytes-1:0]     wr_mask;
  logic [mem_msg_pkg::data_bits-1:0]      old_word;
  logic [mem_msg_pkg::data_bits-1:0]      wr_word;
  logic [mem_msg_pkg::data_bytes-1:0]     rd_mask;
  logic [mem_msg_pkg::data_bits-1:0]      rd_bits;
  logic                                   accept;
  logic                                   is_write;

  // Access register, then response register
  logic                                   acc_val;
  mem_msg_pkg::mem_resp_msg_t             acc_msg;
  logic                                   acc_go;
  logic                                   resp_val;
  mem_msg_pkg::mem_resp_msg_t             resp_msg;

  // Low len bytes enabled, all of them for len 0
  function automatic logic [mem_msg_pkg::data_bytes-1:0] byte_mask(
    input logic [mem_msg_pkg::len_bits-1:0] len
  );
    logic [mem_msg_pkg::data_bytes-1:0] mask;
    for (int b = 0; b < mem_msg_pkg::data_bytes; b++) begin
      mask[b] = (len == '0) || (b < int'(len));
    end
    return mask;
  endfunction

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  assign acc_go   = acc_val && (!resp_val || out_rdy);
  assign in_rdy   = !acc_val || acc_go;
  assign accept   = in_val && in_rdy;
  assign is_write = (in_msg.op == mem_msg_pkg::mem_op_write);

  assign out_val = resp_val;
  assign out_msg = resp_msg;

  // --------------------------------------------------------------------------
  // Storage access
  // --------------------------------------------------------------------------

  // Word index from addr[7:2]
  assign idx = in_msg.addr[mem_msg_pkg::mem_index_bits+1:2];

  // Unwritten words read as zero
  assign old_word = written[idx] ? mem[idx] : '0;
  assign wr_mask  = byte_mask(in_msg.len);

  // Merge enabled request bytes over the old word
  always_comb begin
    for (int b = 0; b < mem_msg_pkg::data_bytes; b++) begin
      wr_word[8*b +: 8] = wr_mask[b] ? in_msg.data[8*b +: 8] : old_word[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (accept && is_write) begin
      mem[idx] <= wr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      written <= '0;
    end else if (accept && is_write) begin
      written[idx] <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Access and response registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_val  <= 1'b0;
      resp_val <= 1'b0;
    end else begin
      if (accept) begin
        acc_val <= 1'b1;
      end else if (acc_go) begin
        acc_val <= 1'b0;
      end
      if (acc_go) begin
        resp_val <= 1'b1;
      end else if (out_rdy) begin
        resp_val <= 1'b0;
      end
    end
  end

  // Echo fields; raw word for reads, zero for writes
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_msg.op     <= in_msg.op;
      acc_msg.opaque <= in_msg.opaque;
      acc_msg.addr   <= in_msg.addr;
      acc_msg.len    <= in_msg.len;
      acc_msg.data   <= is_write ? '0 : old_word;
    end
  end

  // Expand the read byte mask to bits
  assign rd_mask = byte_mask(acc_msg.len);

  always_comb begin
    for (int b = 0; b < mem_msg_pkg::data_bytes; b++) begin
      rd_bits[8*b +: 8] = {8{rd_mask[b]}};
    end
  end

  // Upper bytes beyond len forced to zero
  always_ff @(posedge clk) begin
    if (acc_go) begin
      resp_msg      <= acc_msg;
      resp_msg.data <= acc_msg.data & rd_bits;
    end
  end

endmodule

/* verilog/mem_delay_stage.sv */
/*
 * Request delay line
 * Shift line of message slots giving every request a minimum hold time,
 * with bubbles collapsing behind a stalled head
 */

`timescale 1ns/1ps

module mem_delay_stage (
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      in_val,
  output logic                      in_rdy,
  input  mem_msg_pkg::mem_req_msg_t in_msg,

  output logic                      out_val,
  input  logic                      out_rdy,
  output mem_msg_pkg::mem_req_msg_t out_msg
);

  // Slot 0 is the tail, the last slot is the head
  mem_msg_pkg::mem_req_msg_t         slot_msg [mem_msg_pkg::mem_delay];
  logic [mem_msg_pkg::mem_delay-1:0] slot_val;
  logic [mem_msg_pkg::mem_delay-1:0] can_load;

  // --------------------------------------------------------------------------
  // Per-slot advance
  // --------------------------------------------------------------------------

  // A slot takes new content if empty or if its own entry moves on
  always_comb begin
    can_load[mem_msg_pkg::mem_delay-1] = !slot_val[mem_msg_pkg::mem_delay-1] || out_rdy;
    for (int i = mem_msg_pkg::mem_delay - 2; i >= 0; i--) begin
      can_load[i] = !slot_val[i] || can_load[i+1];
    end
  end

  // Accept only while a bubble exists somewhere ahead
  assign in_rdy = can_load[0];

  assign out_val = slot_val[mem_msg_pkg::mem_delay-1];
  assign out_msg = slot_msg[mem_msg_pkg::mem_delay-1];

  // --------------------------------------------------------------------------
  // Valid flags
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_val <= '0;
    end else begin
      for (int i = mem_msg_pkg::mem_delay - 1; i > 0; i--) begin
        if (can_load[i]) begin
          slot_val[i] <= slot_val[i-1];
        end
      end
      // New request lands in the tail
      if (can_load[0]) begin
        slot_val[0] <= in_val;
      end
    end
  end

  // Message slots, only moved when carrying a valid entry
  always_ff @(posedge clk) begin
    for (int i = mem_msg_pkg::mem_delay - 1; i > 0; i--) begin
      if (can_load[i] && slot_val[i-1]) begin
        slot_msg[i] <= slot_msg[i-1];
      end
    end
    if (can_load[0] && in_val) begin
      slot_msg[0] <= in_msg;
    end
  end

endmodule

/* verilog/mem_req_stage.sv */
/*
 * Request input stage
 * One-entry register between the request port and the delay line
 */

`timescale 1ns/1ps

module mem_req_stage (
  input  logic                      clk,
  input  logic                      rst,

  input  logic                      in_val,
  output logic                      in_rdy,
  input  mem_msg_pkg::mem_req_msg_t in_msg,

  output logic                      out_val,
  input  logic                      out_rdy,
  output mem_msg_pkg::mem_req_msg_t out_msg
);

  logic                      full;
  mem_msg_pkg::mem_req_msg_t msg_q;
  logic                      in_go;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------

  // Empty, or the held entry drains this edge
  assign in_rdy = !full || out_rdy;
  assign in_go  = in_val && in_rdy;

  assign out_val = full;
  assign out_msg = msg_q;

  // --------------------------------------------------------------------------
  // Occupancy
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_go) begin
      // Refill, possibly on the same edge as the drain
      full <= 1'b1;
    end else if (out_rdy) begin
      full <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (in_go) begin
      msg_q <= in_msg;
    end
  end

endmodule

/* verilog/mem_msg_pkg.sv */
/*
 * Memory server message package
 * Sizes, operation encoding and the request/response message formats
 */

package mem_msg_pkg;

  // --------------------------------------------------------------------------
  // Message field widths
  // --------------------------------------------------------------------------

  localparam int addr_bits   = 32;
  localparam int data_bits   = 32;
  localparam int len_bits    = 2;
  localparam int opaque_bits = 8;

  // Bytes per data word
  localparam int data_bytes = data_bits / 8;

  // --------------------------------------------------------------------------
  // Storage and pipeline sizes
  // --------------------------------------------------------------------------

  // 64 words, indexed by addr[7:2]
  localparam int mem_words      = 64;
  localparam int mem_index_bits = 6;

  // Fixed hold time in the delay line
  localparam int mem_delay = 2;

  // Response FIFO
  localparam int resp_depth    = 4;
  localparam int resp_ptr_bits = $clog2(resp_depth);

  // --------------------------------------------------------------------------
  // Operations and messages
  // --------------------------------------------------------------------------

  typedef enum logic {
    mem_op_read  = 1'b0,
    mem_op_write = 1'b1
  } mem_op_e;

  // Request, 75 bits; len 0 means a full word
  typedef struct packed {
    mem_op_e                op;
    logic [opaque_bits-1:0] opaque;
    logic [addr_bits-1:0]   addr;
    logic [len_bits-1:0]    len;
    logic [data_bits-1:0]   data;
  } mem_req_msg_t;

  // Response, same layout; data is read data, zero on writes
  typedef struct packed {
    mem_op_e                op;
    logic [opaque_bits-1:0] opaque;
    logic [addr_bits-1:0]   addr;
    logic [len_bits-1:0]    len;
    logic [data_bits-1:0]   data;
  } mem_resp_msg_t;

endpackage
